// ==== imm_disp_pkg.sv ====
package imm_disp_pkg;

   // window and result sizes
   localparam int WIN_BYTES = 8;
   localparam int IMM_W     = 48;
   localparam int DISP_W    = 32;

   // apb widths
   localparam int APB_AW = 8;
   localparam int APB_DW = 32;

   typedef enum logic [1:0] {
      OPSZ_16 = 2'd0,
      OPSZ_32 = 2'd1,
      OPSZ_48 = 2'd2
   } opsz_e;

   typedef enum logic [1:0] {
      S_IDLE   = 2'd0,
      S_ALIGN  = 2'd1,
      S_EXTEND = 2'd2,
      S_DONE   = 2'd3
   } ctrl_state_e;

   // aligner to extender, fields sit at bit 0 but are not masked yet
   typedef struct packed {
      logic              valid;
      logic [IMM_W-1:0]  imm_raw;
      logic [DISP_W-1:0] disp_raw;
      logic [3:0]        imm_bytes;
      logic [3:0]        disp_bytes;
      opsz_e             opsz;
   } aligned_t;

   typedef struct packed {
      logic              valid;
      logic [IMM_W-1:0]  imm;
      logic [DISP_W-1:0] disp;
   } field_result_t;

   // register byte offsets
   localparam logic [APB_AW-1:0] REG_WIN_HI = 8'h00;
   localparam logic [APB_AW-1:0] REG_WIN_LO = 8'h04;
   localparam logic [APB_AW-1:0] REG_CTRL   = 8'h08;
   localparam logic [APB_AW-1:0] REG_STATUS = 8'h0C;
   localparam logic [APB_AW-1:0] REG_IMM_LO = 8'h10;
   localparam logic [APB_AW-1:0] REG_IMM_HI = 8'h14;
   localparam logic [APB_AW-1:0] REG_DISP   = 8'h18;

endpackage

// ==== decode_req_if.sv ====
interface decode_req_if;
   import imm_disp_pkg::*;

   // one-cycle request strobe
   logic                   valid;
   // byte 0 of the window in the top byte
   logic [WIN_BYTES*8-1:0] window;
   logic [3:0]             disp_bytes;
   logic [3:0]             imm_bytes;
   opsz_e                  opsz;

   modport ctrl (
      output valid,
      output window,
      output disp_bytes,
      output imm_bytes,
      output opsz
   );

   modport aligner (
      input valid,
      input window,
      input disp_bytes,
      input imm_bytes,
      input opsz
   );

endinterface

// ==== byte_shifter_right.sv ====
module byte_shifter_right #(
   parameter int NBYTES = 8
) (
   input  logic [NBYTES*8-1:0]       in,
   output logic [NBYTES*8-1:0]       out,
   input  logic [$clog2(NBYTES)-1:0] shift_amount
);

   // each output byte picks the input byte shift_amount above it
   always_comb begin
      out = '0;
      for (int i = 0; i < NBYTES; i++) begin
         // bytes shifted in from past the top stay zero
         if (i + int'(shift_amount) < NBYTES) begin
            out[i*8 +: 8] = in[(i + int'(shift_amount))*8 +: 8];
         end
      end
   end

endmodule

// ==== field_aligner.sv ====
module field_aligner (
   input  logic                   clk,
   input  logic                   rst_n,
   decode_req_if.aligner          req,
   output imm_disp_pkg::aligned_t aligned
);
   import imm_disp_pkg::*;

   logic [WIN_BYTES*8-1:0] win_le;
   logic [WIN_BYTES*8-1:0] imm_shifted;
   logic [WIN_BYTES*8-1:0] disp_shifted;
   logic                   valid_q;
   logic [IMM_W-1:0]       imm_q;
   logic [DISP_W-1:0]      disp_q;
   logic [3:0]             imm_bytes_q;
   logic [3:0]             disp_bytes_q;
   opsz_e                  opsz_q;

   // endian swap, window byte 0 goes to bits 7:0
   always_comb begin
      for (int i = 0; i < WIN_BYTES; i++) begin
         win_le[i*8 +: 8] = req.window[(WIN_BYTES-1-i)*8 +: 8];
      end
   end

   // immediate follows the displacement bytes
   byte_shifter_right #(.NBYTES(WIN_BYTES)) imm_shift_i (
      .in           (win_le),
      .out          (imm_shifted),
      .shift_amount (req.disp_bytes[2:0])
   );

   // displacement already starts at byte 0
   byte_shifter_right #(.NBYTES(WIN_BYTES)) disp_shift_i (
      .in           (win_le),
      .out          (disp_shifted),
      .shift_amount (3'd0)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= req.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (req.valid) begin
         imm_q        <= imm_shifted[IMM_W-1:0];
         disp_q       <= disp_shifted[DISP_W-1:0];
         imm_bytes_q  <= req.imm_bytes;
         disp_bytes_q <= req.disp_bytes;
         opsz_q       <= req.opsz;
      end
   end

   always_comb begin
      aligned.valid      = valid_q;
      aligned.imm_raw    = imm_q;
      aligned.disp_raw   = disp_q;
      aligned.imm_bytes  = imm_bytes_q;
      aligned.disp_bytes = disp_bytes_q;
      aligned.opsz       = opsz_q;
   end

endmodule

// ==== field_extender.sv ====
module field_extender (
   input  logic                        clk,
   input  logic                        rst_n,
   input  imm_disp_pkg::aligned_t      aligned,
   output imm_disp_pkg::field_result_t res
);
   import imm_disp_pkg::*;

   logic [2:0]             imm_gap;
   logic [1:0]             disp_gap;
   logic [WIN_BYTES*8-1:0] imm_mask;
   logic [DISP_W-1:0]      disp_mask;
   logic [IMM_W-1:0]       imm_ext;
   logic [DISP_W-1:0]      disp_ext;
   logic [IMM_W-1:0]       imm_val;
   logic [DISP_W-1:0]      disp_val;
   logic                   valid_q;
   logic [IMM_W-1:0]       imm_q;
   logic [DISP_W-1:0]      disp_q;

   // bytes missing from a full 6-byte immediate
   assign imm_gap  = 3'd6 - aligned.imm_bytes[2:0];
   // 4 - disp_bytes, modulo 4
   assign disp_gap = 2'd0 - aligned.disp_bytes[1:0];

   // ones over the low 48 bits, shifted down to imm_bytes bytes
   byte_shifter_right #(.NBYTES(WIN_BYTES)) imm_mask_i (
      .in           ({{(WIN_BYTES*8-IMM_W){1'b0}}, {IMM_W{1'b1}}}),
      .out          (imm_mask),
      .shift_amount (imm_gap)
   );

   // zero-length disp gives all ones here, cleared below
   byte_shifter_right #(.NBYTES(DISP_W/8)) disp_mask_i (
      .in           ({DISP_W{1'b1}}),
      .out          (disp_mask),
      .shift_amount (disp_gap)
   );

   // sign extension only for 1-byte fields
   always_comb begin
      imm_ext  = '0;
      disp_ext = '0;
      if (aligned.imm_bytes == 4'd1) begin
         if (aligned.opsz == OPSZ_16) begin
            imm_ext[15:8] = {8{aligned.imm_raw[7]}};
         end else begin
            imm_ext[31:8] = {24{aligned.imm_raw[7]}};
         end
      end
      if (aligned.disp_bytes == 4'd1) begin
         disp_ext[31:8] = {24{aligned.disp_raw[7]}};
      end
   end

   assign imm_val  = (aligned.imm_raw & imm_mask[IMM_W-1:0]) | imm_ext;
   assign disp_val = (aligned.disp_bytes == 4'd0) ? '0
                                                  : (aligned.disp_raw & disp_mask) | disp_ext;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= aligned.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (aligned.valid) begin
         imm_q  <= imm_val;
         disp_q <= disp_val;
      end
   end

   always_comb begin
      res.valid = valid_q;
      res.imm   = imm_q;
      res.disp  = disp_q;
   end

endmodule

// ==== decode_ctrl.sv ====
module decode_ctrl (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [imm_disp_pkg::APB_AW-1:0] paddr,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic [imm_disp_pkg::APB_DW-1:0] pwdata,
   output logic [imm_disp_pkg::APB_DW-1:0] prdata,
   output logic                            pslverr,
   decode_req_if.ctrl                      req,
   input  imm_disp_pkg::field_result_t     res
);
   import imm_disp_pkg::*;

   ctrl_state_e       state_q;
   logic [31:0]       win_hi_q;
   logic [31:0]       win_lo_q;
   logic [3:0]        disp_bytes_q;
   logic [3:0]        imm_bytes_q;
   opsz_e             opsz_q;
   logic              req_valid_q;
   logic              done_q;
   logic              err_q;
   logic [IMM_W-1:0]  imm_q;
   logic [DISP_W-1:0] disp_q;
   logic              busy;
   logic              access;
   logic              addr_hit;
   logic              read_only;
   logic              wr_en;
   logic              ctrl_wr;
   logic              start;
   logic              len_ok;
   logic [3:0]        wr_disp;
   logic [3:0]        wr_imm;
   logic [4:0]        len_sum;

   assign busy   = (state_q == S_ALIGN) || (state_q == S_EXTEND);
   assign access = psel && penable;

   // address decode
   always_comb begin
      addr_hit  = 1'b0;
      read_only = 1'b0;
      case (paddr)
         REG_WIN_HI, REG_WIN_LO, REG_CTRL: begin
            addr_hit = 1'b1;
         end
         REG_STATUS, REG_IMM_LO, REG_IMM_HI, REG_DISP: begin
            addr_hit  = 1'b1;
            read_only = 1'b1;
         end
         default: addr_hit = 1'b0;
      endcase
   end

   // CTRL write while busy is rejected too
   assign pslverr = access && (!addr_hit ||
                    (pwrite && (read_only || (paddr == REG_CTRL && busy))));
   assign wr_en   = access && pwrite && !pslverr;
   assign ctrl_wr = wr_en && (paddr == REG_CTRL);
   assign start   = ctrl_wr && pwdata[31];

   // length check on the value being written
   assign wr_disp = pwdata[3:0];
   assign wr_imm  = pwdata[7:4];
   assign len_sum = {1'b0, wr_disp} + {1'b0, wr_imm};
   assign len_ok  = (wr_disp inside {4'd0, 4'd1, 4'd4}) &&
                    (wr_imm inside {4'd0, 4'd1, 4'd2, 4'd4, 4'd6}) &&
                    (len_sum <= 5'd8);

   always_ff @(posedge clk) begin
      if (wr_en && paddr == REG_WIN_HI) begin
         win_hi_q <= pwdata;
      end
      if (wr_en && paddr == REG_WIN_LO) begin
         win_lo_q <= pwdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         disp_bytes_q <= '0;
         imm_bytes_q  <= '0;
         opsz_q       <= OPSZ_16;
      end else if (ctrl_wr) begin
         disp_bytes_q <= wr_disp;
         imm_bytes_q  <= wr_imm;
         opsz_q       <= opsz_e'(pwdata[9:8]);
      end
   end

   // sequencing, results captured on res.valid
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q     <= S_IDLE;
         req_valid_q <= 1'b0;
         done_q      <= 1'b0;
         err_q       <= 1'b0;
         imm_q       <= '0;
         disp_q      <= '0;
      end else begin
         req_valid_q <= 1'b0;
         case (state_q)
            S_IDLE, S_DONE: begin
               state_q <= S_IDLE;
               if (start && len_ok) begin
                  state_q     <= S_ALIGN;
                  req_valid_q <= 1'b1;
                  done_q      <= 1'b0;
                  err_q       <= 1'b0;
               end else if (start) begin
                  // bad lengths finish at once with zero results
                  state_q <= S_DONE;
                  done_q  <= 1'b1;
                  err_q   <= 1'b1;
                  imm_q   <= '0;
                  disp_q  <= '0;
               end
            end
            S_ALIGN: state_q <= S_EXTEND;
            S_EXTEND: begin
               if (res.valid) begin
                  state_q <= S_DONE;
                  imm_q   <= res.imm;
                  disp_q  <= res.disp;
                  done_q  <= 1'b1;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   assign req.valid      = req_valid_q;
   assign req.window     = {win_hi_q, win_lo_q};
   assign req.disp_bytes = disp_bytes_q;
   assign req.imm_bytes  = imm_bytes_q;
   assign req.opsz       = opsz_q;

   // read mux, start reads back as 0
   always_comb begin
      case (paddr)
         REG_WIN_HI: prdata = win_hi_q;
         REG_WIN_LO: prdata = win_lo_q;
         REG_CTRL:   prdata = {22'b0, opsz_q, imm_bytes_q, disp_bytes_q};
         REG_STATUS: prdata = {29'b0, err_q, done_q, busy};
         REG_IMM_LO: prdata = imm_q[31:0];
         REG_IMM_HI: prdata = {16'b0, imm_q[IMM_W-1:32]};
         REG_DISP:   prdata = disp_q;
         default:    prdata = '0;
      endcase
   end

endmodule

// ==== imm_disp_top.sv ====
module imm_disp_top (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [imm_disp_pkg::APB_AW-1:0] paddr,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic [imm_disp_pkg::APB_DW-1:0] pwdata,
   output logic [imm_disp_pkg::APB_DW-1:0] prdata,
   output logic                            pready,
   output logic                            pslverr
);
   import imm_disp_pkg::*;

   aligned_t      aligned;
   field_result_t res;

   decode_req_if req_if ();

   // zero wait states on every transfer
   assign pready = 1'b1;

   decode_ctrl decode_ctrl_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pslverr (pslverr),
      .req     (req_if.ctrl),
      .res     (res)
   );

   // stage 1, swap and shift
   field_aligner field_aligner_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req_if.aligner),
      .aligned (aligned)
   );

   // stage 2, mask and extend
   field_extender field_extender_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .aligned (aligned),
      .res     (res)
   );

endmodule

// ==== tb_imm_disp_top.sv ====
module tb_imm_disp_top;
   timeunit 1ns;
   timeprecision 100ps;
   import imm_disp_pkg::*;

   // each test gets its APB accesses at 2 cycles, the pipeline and some polling slack
   localparam int N_TESTS      = 84 + 3 + 200 + 3;
   localparam int ACC_PER_TEST = 10;
   localparam int RESET_CYCLES = 8;
   localparam int CYCLE_LIMIT  = N_TESTS * (ACC_PER_TEST * 2 + 3 + 10) + RESET_CYCLES;

   typedef struct packed {
      logic              err;
      logic [IMM_W-1:0]  imm;
      logic [DISP_W-1:0] disp;
   } expect_t;

   logic              clk;
   logic              rst_n;
   logic [APB_AW-1:0] paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [APB_DW-1:0] pwdata;
   logic [APB_DW-1:0] prdata;
   logic              pready;
   logic              pslverr;
   logic [15:0]       lfsr;
   int                n_pass;
   int                n_fail;
   int                cycles;

   imm_disp_top imm_disp_top_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   task automatic rand_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[62:0], lfsr[0]};
      end
   endtask

   function automatic logic [3:0] disp_opt(input int k);
      return (k == 0) ? 4'd0 : (k == 1) ? 4'd1 : 4'd4;
   endfunction

   function automatic logic [3:0] imm_opt(input int k);
      case (k)
         0: return 4'd0;
         1: return 4'd1;
         2: return 4'd2;
         3: return 4'd4;
         default: return 4'd6;
      endcase
   endfunction

   // instruction byte k sits in window bits 63-8k down, fields little-endian
   function automatic expect_t ref_decode(input logic [63:0] win, input logic [3:0] d,
                                          input logic [3:0] i, input opsz_e opsz);
      expect_t    e;
      logic [7:0] b [8];
      int         ext_w;
      e = '0;
      for (int k = 0; k < 8; k++) begin
         b[k] = win[63-8*k -: 8];
      end
      if (!(d inside {0, 1, 4}) || !(i inside {0, 1, 2, 4, 6}) || (d + i > 8)) begin
         e.err = 1'b1;
         return e;
      end
      for (int k = 0; k < d; k++) begin
         e.disp[8*k +: 8] = b[k];
      end
      for (int k = 0; k < i; k++) begin
         e.imm[8*k +: 8] = b[d+k];
      end
      if (d == 1 && b[0][7]) begin
         e.disp[31:8] = '1;
      end
      ext_w = (opsz == OPSZ_16) ? 16 : 32;
      if (i == 1 && b[d][7]) begin
         for (int k = 8; k < ext_w; k++) begin
            e.imm[k] = 1'b1;
         end
      end
      return e;
   endfunction

   task automatic check_imm(input string what, input logic [IMM_W-1:0] exp,
                            input logic [IMM_W-1:0] act);
      if (act !== exp) begin
         n_fail++;
         $display("ERR %s exp 0x%012h got 0x%012h", what, exp, act);
      end else begin
         n_pass++;
      end
   endtask

   task automatic check_disp(input string what, input logic [DISP_W-1:0] exp,
                             input logic [DISP_W-1:0] act);
      if (act !== exp) begin
         n_fail++;
         $display("ERR %s exp 0x%08h got 0x%08h", what, exp, act);
      end else begin
         n_pass++;
      end
   endtask

   // status bits are err, done, busy
   task automatic check_status(input string what, input logic [2:0] exp, input logic [2:0] act);
      if (act !== exp) begin
         n_fail++;
         $display("ERR %s exp 0x%0h got 0x%0h", what, exp, act);
      end else begin
         n_pass++;
      end
   endtask

   task automatic check_reg(input string what, input logic [APB_DW-1:0] exp,
                            input logic [APB_DW-1:0] act);
      if (act !== exp) begin
         n_fail++;
         $display("ERR %s exp 0x%08h got 0x%08h", what, exp, act);
      end else begin
         n_pass++;
      end
   endtask

   task automatic check_slverr(input logic [APB_AW-1:0] addr, input logic exp, input logic act);
      if (act !== exp) begin
         n_fail++;
         $display("ERR pslverr at 0x%02h exp 0x%0h got 0x%0h", addr, exp, act);
      end else begin
         n_pass++;
      end
   endtask

   // zero wait states, so pready is high in every access phase
   task automatic check_ready(input logic [APB_AW-1:0] addr, input logic act);
      if (act !== 1'b1) begin
         n_fail++;
         $display("ERR pready at 0x%02h exp 0x1 got 0x%0h", addr, act);
      end else begin
         n_pass++;
      end
   endtask

   // outputs sampled 1 ns into the access phase, before the completing edge
   task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                            input logic exp_err);
      logic err;
      logic rdy;
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      #1;
      err = pslverr;
      rdy = pready;
      @(posedge clk);
      check_slverr(addr, exp_err, err);
      check_ready(addr, rdy);
   endtask

   task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
      logic err;
      logic rdy;
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      #1;
      data = prdata;
      err  = pslverr;
      rdy  = pready;
      @(posedge clk);
      check_slverr(addr, 1'b0, err);
      check_ready(addr, rdy);
   endtask

   task automatic idle_cycle();
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_results(output logic [IMM_W-1:0] imm, output logic [DISP_W-1:0] disp);
      logic [APB_DW-1:0] lo;
      logic [APB_DW-1:0] hi;
      apb_read(REG_IMM_LO, lo);
      apb_read(REG_IMM_HI, hi);
      apb_read(REG_DISP, disp);
      imm = {hi[15:0], lo};
   endtask

   task automatic wait_done();
      logic [APB_DW-1:0] st;
      int                polls;
      polls = 0;
      do begin
         apb_read(REG_STATUS, st);
         polls++;
      end while (!st[1] && polls < 10);
      if (!st[1]) begin
         n_fail++;
         $display("decode did not finish within 10 status reads");
      end
   endtask

   // probes see the state after edges 1 and 3 past the start access, or 2 and 4 when late
   task automatic run_decode(input logic [63:0] win, input logic [3:0] d, input logic [3:0] i,
                             input opsz_e opsz, input logic late_probe);
      expect_t           e;
      logic [APB_DW-1:0] st;
      logic [IMM_W-1:0]  imm;
      logic [DISP_W-1:0] disp;
      e = ref_decode(win, d, i, opsz);
      apb_write(REG_WIN_HI, win[63:32], 1'b0);
      apb_write(REG_WIN_LO, win[31:0], 1'b0);
      apb_write(REG_CTRL, {1'b1, 21'b0, opsz, i, d}, 1'b0);
      if (e.err) begin
         apb_read(REG_STATUS, st);
         check_status("status", 3'b110, st[2:0]);
      end else begin
         if (late_probe) begin
            idle_cycle();
         end
         apb_read(REG_STATUS, st);
         check_status("status", 3'b001, st[2:0]);
         apb_read(REG_STATUS, st);
         check_status("status", 3'b010, st[2:0]);
      end
      read_results(imm, disp);
      check_imm("imm", e.imm, imm);
      check_disp("disp", e.disp, disp);
   endtask

   task automatic end_test(input string name, input int fails_before);
      $display("test %-14s %s", name, (n_fail == fails_before) ? "ok" : "failed");
   endtask

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout, run went past %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      logic [63:0]       win;
      logic [63:0]       r;
      logic [APB_DW-1:0] rd;
      logic [IMM_W-1:0]  imm;
      logic [DISP_W-1:0] disp;
      logic [3:0]        d;
      logic [3:0]        i;
      logic [1:0]        o;
      expect_t           e;
      int                mark;
      rst_n   = 1'b0;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      lfsr    = 16'd65303;
      n_pass  = 0;
      n_fail  = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      mark = n_fail;
      apb_read(REG_STATUS, rd);
      check_status("status", 3'b000, rd[2:0]);
      read_results(imm, disp);
      check_imm("imm", '0, imm);
      check_disp("disp", '0, disp);
      end_test("reset", mark);

      // 1-byte fields get their sign bit forced both ways
      mark = n_fail;
      for (int di = 0; di < 3; di++) begin
         for (int ii = 0; ii < 5; ii++) begin
            for (int oz = 0; oz < 3; oz++) begin
               for (int sg = 0; sg < 2; sg++) begin
                  d = disp_opt(di);
                  i = imm_opt(ii);
                  if (d + i > 8) begin
                     continue;
                  end
                  rand_bits(64, win);
                  if (d == 1) begin
                     win[63] = sg[0];
                  end
                  if (i == 1) begin
                     win[63-8*d] = sg[0];
                  end
                  run_decode(win, d, i, opsz_e'(oz), sg[0]);
               end
            end
         end
      end
      end_test("legal_pairs", mark);

      mark = n_fail;
      rand_bits(64, win);
      run_decode(win, 4'd2, 4'd0, OPSZ_32, 1'b0);
      run_decode(win, 4'd0, 4'd3, OPSZ_16, 1'b0);
      run_decode(win, 4'd4, 4'd6, OPSZ_48, 1'b0);
      end_test("illegal_len", mark);

      mark = n_fail;
      for (int n = 0; n < 200; n++) begin
         do begin
            rand_bits(8, r);
            d = disp_opt(r % 3);
            rand_bits(8, r);
            i = imm_opt(r % 5);
         end while (d + i > 8);
         rand_bits(8, r);
         o = r % 3;
         rand_bits(64, win);
         run_decode(win, d, i, opsz_e'(o), n[0]);
      end
      end_test("random", mark);

      // second start lands while the first decode is busy
      mark = n_fail;
      rand_bits(64, win);
      e = ref_decode(win, 4'd4, 4'd2, OPSZ_32);
      apb_write(REG_WIN_HI, win[63:32], 1'b0);
      apb_write(REG_WIN_LO, win[31:0], 1'b0);
      apb_write(REG_CTRL, 32'h8000_0124, 1'b0);
      apb_write(REG_CTRL, 32'h8000_0011, 1'b1);
      apb_write(8'h20, 32'h0, 1'b1);
      apb_write(REG_DISP, 32'hFFFF_FFFF, 1'b1);
      wait_done();
      read_results(imm, disp);
      check_imm("imm", e.imm, imm);
      check_disp("disp", e.disp, disp);
      apb_read(REG_CTRL, rd);
      check_reg("ctrl", 32'h0000_0124, rd);
      end_test("apb_errors", mark);

      mark = n_fail;
      rand_bits(64, win);
      e = ref_decode(win, 4'd1, 4'd4, OPSZ_48);
      apb_write(REG_WIN_HI, win[63:32], 1'b0);
      apb_write(REG_WIN_LO, win[31:0], 1'b0);
      apb_write(REG_CTRL, 32'h8000_0241, 1'b0);
      apb_read(REG_WIN_HI, rd);
      check_reg("win_hi", win[63:32], rd);
      apb_read(REG_WIN_LO, rd);
      check_reg("win_lo", win[31:0], rd);
      apb_read(REG_CTRL, rd);
      check_reg("ctrl", 32'h0000_0241, rd);
      wait_done();
      read_results(imm, disp);
      check_imm("imm", e.imm, imm);
      check_disp("disp", e.disp, disp);
      end_test("readback", mark);
      idle_cycle();

      $display("checks passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== imm_disp.f ====
imm_disp_pkg.sv
decode_req_if.sv
byte_shifter_right.sv
field_aligner.sv
field_extender.sv
decode_ctrl.sv
imm_disp_top.sv
tb_imm_disp_top.sv
